// File: source/resp_bank_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Sizes, derived widths and the message word for the write-response bank
////////////////////////////////////////////////////////////////////////////

package resp_bank_pkg;

  // AXI ID field
  localparam int IdWidth = 2;
  localparam int NumIds = 2 ** IdWidth;

  // Message layout
  localparam int PayloadWidth = 14;
  localparam int MsgWidth = PayloadWidth + IdWidth;

  // Bank capacity
  localparam int NumSlots = 16;
  localparam int SlotAddrWidth = $clog2(NumSlots);
  // Counts run from 0 up to NumSlots inclusive
  localparam int CountWidth = $clog2(NumSlots + 1);

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [SlotAddrWidth-1:0] slot_addr_t;

  // Raw word for storage, field view for routing by ID
  typedef union packed {
    logic [MsgWidth-1:0] raw;
    struct packed {
      logic [PayloadWidth-1:0] payload;
      id_t                     id;
    } fields;
  } msg_u;

endpackage

// File: source/slot_allocator.sv
////////////////////////////////////////////////////////////////////////////
// Slot occupancy, lowest-free search and reservation handshake
////////////////////////////////////////////////////////////////////////////

module slot_allocator (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  resp_bank_pkg::id_t                  reserve_id_i,
  input  logic                                reserve_ready_i,
  output logic                                reserve_valid_o,
  output resp_bank_pkg::slot_addr_t           reserve_addr_o,
  input  logic [resp_bank_pkg::NumSlots-1:0]  free_mask_i,
  output logic [resp_bank_pkg::NumIds-1:0]    res_push_o
);

  logic [resp_bank_pkg::NumSlots-1:0] occupied_q;
  logic [resp_bank_pkg::NumSlots-1:0] free_slots;
  logic [resp_bank_pkg::NumSlots-1:0] take_mask;
  logic                               accept;

  // A slot released this cycle may be handed out again at once
  assign free_slots = ~occupied_q | free_mask_i;
  assign reserve_valid_o = |free_slots;
  assign accept = reserve_valid_o & reserve_ready_i;

  // Priority search, lowest index wins
  always_comb begin
    reserve_addr_o = '0;
    for (int i = resp_bank_pkg::NumSlots - 1; i >= 0; i--) begin
      if (free_slots[i]) begin
        reserve_addr_o = resp_bank_pkg::slot_addr_t'(i);
      end
    end
  end

  always_comb begin
    take_mask = '0;
    take_mask[reserve_addr_o] = accept;
  end

  // Route the accepted reservation to the queue of its ID
  always_comb begin
    res_push_o = '0;
    res_push_o[reserve_id_i] = accept;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= (occupied_q & ~free_mask_i) | take_mask;
    end
  end

  // Never hand out a slot that is still held and not being released
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (!occupied_q[reserve_addr_o] || free_mask_i[reserve_addr_o]));

endmodule

// File: source/id_slot_queue.sv
////////////////////////////////////////////////////////////////////////////
// Per-ID queue of reserved slot addresses with fill and head tracking
////////////////////////////////////////////////////////////////////////////

module id_slot_queue (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                push_i,
  input  resp_bank_pkg::slot_addr_t           push_addr_i,
  input  logic                                fill_i,
  input  logic [resp_bank_pkg::NumSlots-1:0]  release_en_i,
  input  logic                                pop_i,
  output logic                                slot_open_o,
  output resp_bank_pkg::slot_addr_t           fill_addr_o,
  output logic                                head_ready_o,
  output resp_bank_pkg::slot_addr_t           head_addr_o
);

  // Slot addresses in reservation order
  resp_bank_pkg::slot_addr_t addr_list_q [resp_bank_pkg::NumSlots];

  resp_bank_pkg::slot_addr_t               head_q;
  resp_bank_pkg::slot_addr_t               tail_q;
  resp_bank_pkg::slot_addr_t               fill_ptr;
  logic [resp_bank_pkg::CountWidth-1:0]    count_q;
  logic [resp_bank_pkg::CountWidth-1:0]    count_d;
  logic [resp_bank_pkg::CountWidth-1:0]    filled_q;
  logic [resp_bank_pkg::CountWidth-1:0]    filled_d;

  // Filled entries sit at the head, the next one to fill follows them
  assign fill_ptr = head_q + resp_bank_pkg::slot_addr_t'(filled_q);
  assign fill_addr_o = addr_list_q[fill_ptr];
  assign slot_open_o = count_q > filled_q;

  assign head_addr_o = addr_list_q[head_q];
  assign head_ready_o = (filled_q != '0) && release_en_i[head_addr_o];

  always_comb begin
    count_d = count_q;
    filled_d = filled_q;
    if (push_i) begin
      count_d = count_d + 1'b1;
    end
    if (fill_i) begin
      filled_d = filled_d + 1'b1;
    end
    // Popped entry leaves both counts
    if (pop_i) begin
      count_d = count_d - 1'b1;
      filled_d = filled_d - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
      filled_q <= '0;
    end else begin
      count_q <= count_d;
      filled_q <= filled_d;
      if (push_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop_i) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_list_q[tail_q] <= push_addr_i;
    end
  end

  // The store only fills an ID that has an open reservation
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_i |-> slot_open_o);

endmodule

// File: source/message_store.sv
////////////////////////////////////////////////////////////////////////////
// Message register array with ID decode, input handshake and read port
////////////////////////////////////////////////////////////////////////////

module message_store (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  in_valid_i,
  input  resp_bank_pkg::msg_u                                   data_i,
  output logic                                                  in_ready_o,
  input  logic [resp_bank_pkg::NumIds-1:0]                      slot_open_i,
  input  resp_bank_pkg::slot_addr_t [resp_bank_pkg::NumIds-1:0] fill_addr_i,
  output logic [resp_bank_pkg::NumIds-1:0]                      fill_en_o,
  input  resp_bank_pkg::slot_addr_t                             rd_addr_i,
  output resp_bank_pkg::msg_u                                   rd_data_o
);

  logic [resp_bank_pkg::MsgWidth-1:0] mem_q [resp_bank_pkg::NumSlots];

  resp_bank_pkg::id_t        in_id;
  resp_bank_pkg::slot_addr_t wr_addr;
  logic                      accept;

  // ID in the low bits picks the queue
  assign in_id = data_i.fields.id;
  assign in_ready_o = slot_open_i[in_id];
  assign wr_addr = fill_addr_i[in_id];
  assign accept = in_valid_i & in_ready_o;

  always_comb begin
    fill_en_o = '0;
    fill_en_o[in_id] = accept;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[wr_addr] <= data_i.raw;
    end
  end

  assign rd_data_o = resp_bank_pkg::msg_u'(mem_q[rd_addr_i]);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> !$isunknown(data_i.raw));

endmodule

// File: source/release_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Lowest-ID release arbiter, output register and freed-slot mask
////////////////////////////////////////////////////////////////////////////

module release_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic [resp_bank_pkg::NumIds-1:0]                      head_ready_i,
  input  resp_bank_pkg::slot_addr_t [resp_bank_pkg::NumIds-1:0] head_addr_i,
  input  resp_bank_pkg::msg_u                                   rd_data_i,
  input  logic                                                  out_ready_i,
  output logic [resp_bank_pkg::NumIds-1:0]                      grant_o,
  output resp_bank_pkg::slot_addr_t                             rd_addr_o,
  output logic [resp_bank_pkg::NumSlots-1:0]                    free_mask_o,
  output logic                                                  out_valid_o,
  output resp_bank_pkg::msg_u                                   data_o
);

  resp_bank_pkg::id_t                 sel_id;
  logic                               can_load;
  logic                               load;
  logic [resp_bank_pkg::NumSlots-1:0] free_mask_d;
  logic                               out_valid_q;
  logic [resp_bank_pkg::NumSlots-1:0] free_mask_q;
  resp_bank_pkg::msg_u                data_q;

  // Register is empty or drains this cycle
  assign can_load = !out_valid_q || out_ready_i;
  assign load = can_load && (|head_ready_i);

  always_comb begin
    sel_id = '0;
    for (int i = resp_bank_pkg::NumIds - 1; i >= 0; i--) begin
      if (head_ready_i[i]) begin
        sel_id = resp_bank_pkg::id_t'(i);
      end
    end
  end

  always_comb begin
    grant_o = '0;
    grant_o[sel_id] = load;
  end

  assign rd_addr_o = head_addr_i[sel_id];

  always_comb begin
    free_mask_d = '0;
    free_mask_d[rd_addr_o] = load;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      free_mask_q <= '0;
    end else begin
      free_mask_q <= free_mask_d;
      if (can_load) begin
        out_valid_q <= load;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= rd_data_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign data_o = data_q;
  assign free_mask_o = free_mask_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(grant_o));

endmodule

// File: source/write_resp_bank.sv
////////////////////////////////////////////////////////////////////////////
// Write-response bank top level
////////////////////////////////////////////////////////////////////////////

module write_resp_bank (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  resp_bank_pkg::id_t                  reserve_id_i,
  input  logic                                reserve_ready_i,
  output logic                                reserve_valid_o,
  output resp_bank_pkg::slot_addr_t           reserve_addr_o,
  input  logic                                in_valid_i,
  input  resp_bank_pkg::msg_u                 data_i,
  output logic                                in_ready_o,
  input  logic [resp_bank_pkg::NumSlots-1:0]  release_en_i,
  input  logic                                out_ready_i,
  output logic                                out_valid_o,
  output resp_bank_pkg::msg_u                 data_o,
  output logic [resp_bank_pkg::NumSlots-1:0]  address_released_onehot_o
);

  // Reservation path
  logic [resp_bank_pkg::NumIds-1:0]   res_push;
  resp_bank_pkg::slot_addr_t          res_addr;

  // Per-ID queue state
  logic [resp_bank_pkg::NumIds-1:0]                      slot_open;
  resp_bank_pkg::slot_addr_t [resp_bank_pkg::NumIds-1:0] fill_addr;
  logic [resp_bank_pkg::NumIds-1:0]                      fill_en;
  logic [resp_bank_pkg::NumIds-1:0]                      head_ready;
  resp_bank_pkg::slot_addr_t [resp_bank_pkg::NumIds-1:0] head_addr;

  // Release path
  logic [resp_bank_pkg::NumIds-1:0]   grant;
  resp_bank_pkg::slot_addr_t          rd_addr;
  resp_bank_pkg::msg_u                rd_data;
  logic [resp_bank_pkg::NumSlots-1:0] free_mask;

  slot_allocator u_slot_allocator (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reserve_id_i    (reserve_id_i),
    .reserve_ready_i (reserve_ready_i),
    .reserve_valid_o (reserve_valid_o),
    .reserve_addr_o  (res_addr),
    .free_mask_i     (free_mask),
    .res_push_o      (res_push)
  );

  assign reserve_addr_o = res_addr;

  for (genvar g = 0; g < resp_bank_pkg::NumIds; g++) begin : gen_id_queue
    id_slot_queue u_id_slot_queue (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .push_i       (res_push[g]),
      .push_addr_i  (res_addr),
      .fill_i       (fill_en[g]),
      .release_en_i (release_en_i),
      .pop_i        (grant[g]),
      .slot_open_o  (slot_open[g]),
      .fill_addr_o  (fill_addr[g]),
      .head_ready_o (head_ready[g]),
      .head_addr_o  (head_addr[g])
    );
  end

  message_store u_message_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .data_i      (data_i),
    .in_ready_o  (in_ready_o),
    .slot_open_i (slot_open),
    .fill_addr_i (fill_addr),
    .fill_en_o   (fill_en),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data)
  );

  release_arbiter u_release_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_ready_i (head_ready),
    .head_addr_i  (head_addr),
    .rd_data_i    (rd_data),
    .out_ready_i  (out_ready_i),
    .grant_o      (grant),
    .rd_addr_o    (rd_addr),
    .free_mask_o  (free_mask),
    .out_valid_o  (out_valid_o),
    .data_o       (data_o)
  );

  assign address_released_onehot_o = free_mask;

endmodule

// File: test/tb_write_resp_bank.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the write-response bank, driven by a stimulus file
////////////////////////////////////////////////////////////////////////////

module tb_write_resp_bank;

  logic                                    clk_i;
  logic                                    rst_ni;
  logic [resp_bank_pkg::IdWidth-1:0]       reserve_id_i;
  logic                                    reserve_ready_i;
  logic                                    reserve_valid_o;
  logic [resp_bank_pkg::SlotAddrWidth-1:0] reserve_addr_o;
  logic                                    in_valid_i;
  logic [resp_bank_pkg::MsgWidth-1:0]      data_i;
  logic                                    in_ready_o;
  logic [resp_bank_pkg::NumSlots-1:0]      release_en_i;
  logic                                    out_ready_i;
  logic                                    out_valid_o;
  logic [resp_bank_pkg::MsgWidth-1:0]      data_o;
  logic [resp_bank_pkg::NumSlots-1:0]      address_released_onehot_o;

  // Released slot masks in the order they were reported
  logic [resp_bank_pkg::NumSlots-1:0] released_q [$];

  int error_count;
  int test_count;
  int failed_tests;
  bit test_ok;

  write_resp_bank uut (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .reserve_id_i              (reserve_id_i),
    .reserve_ready_i           (reserve_ready_i),
    .reserve_valid_o           (reserve_valid_o),
    .reserve_addr_o            (reserve_addr_o),
    .in_valid_i                (in_valid_i),
    .data_i                    (data_i),
    .in_ready_o                (in_ready_o),
    .release_en_i              (release_en_i),
    .out_ready_i               (out_ready_i),
    .out_valid_o               (out_valid_o),
    .data_o                    (data_o),
    .address_released_onehot_o (address_released_onehot_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Release pulse lasts one cycle, so catch it mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && (address_released_onehot_o != '0)) begin
      released_q.push_back(address_released_onehot_o);
    end
  end

  // Payload in the upper bits, ID in the low bits
  function automatic logic [resp_bank_pkg::MsgWidth-1:0] msg_word(input int id, input int payload);
    return {payload[resp_bank_pkg::PayloadWidth-1:0], id[resp_bank_pkg::IdWidth-1:0]};
  endfunction

  function automatic bit signal_high(input string name);
    case (name)
      "reserve_valid_o": return reserve_valid_o;
      "in_ready_o":      return in_ready_o;
      default:           return out_valid_o;
    endcase
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic wait_high(input string name, output bit seen);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!signal_high(name) && waited < 50) begin
      @(negedge clk_i);
      waited++;
    end
    seen = signal_high(name);
    if (!seen) begin
      $display("Timeout at %0t: %s stayed low for 50 cycles", $time, name);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic reserve_slot(input int id, input int exp_addr);
    bit seen;
    @(posedge clk_i);
    reserve_id_i <= resp_bank_pkg::id_t'(id);
    reserve_ready_i <= 1'b1;
    wait_high("reserve_valid_o", seen);
    if (seen) begin
      check_value(reserve_addr_o, exp_addr, "reserve_addr_o");
    end
    @(posedge clk_i);
    reserve_ready_i <= 1'b0;
  endtask

  task automatic send_message(input int id, input int payload, input int exp_ready);
    bit seen;
    @(posedge clk_i);
    data_i <= msg_word(id, payload);
    if (exp_ready == 0) begin
      @(negedge clk_i);
      check_value(in_ready_o, 0, "in_ready_o");
    end else begin
      in_valid_i <= 1'b1;
      wait_high("in_ready_o", seen);
      @(posedge clk_i);
      in_valid_i <= 1'b0;
    end
  endtask

  task automatic set_release(input int mask, input int exp_valid);
    @(posedge clk_i);
    release_en_i <= mask[resp_bank_pkg::NumSlots-1:0];
    // Eligible in the next cycle, visible after the edge that ends it
    @(posedge clk_i);
    @(negedge clk_i);
    check_value(out_valid_o, exp_valid, "out_valid_o");
  endtask

  task automatic take_output(input int id, input int payload, input int exp_slot);
    bit seen;
    wait_high("out_valid_o", seen);
    if (seen) begin
      check_value(data_o, msg_word(id, payload), "data_o");
      @(posedge clk_i);
      out_ready_i <= 1'b1;
      // A freed slot loses its release enable before it is reserved again
      release_en_i <= release_en_i & ~exp_slot[resp_bank_pkg::NumSlots-1:0];
      if (released_q.size() == 0) begin
        $display("No released slot was reported for the output at %0t", $time);
        error_count++;
        test_ok = 1'b0;
      end else begin
        check_value(released_q.pop_front(), exp_slot, "address_released_onehot_o");
      end
      @(posedge clk_i);
      out_ready_i <= 1'b0;
    end
  endtask

  task automatic hold_output(input int id, input int payload, input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_value(out_valid_o, 1, "out_valid_o");
      check_value(data_o, msg_word(id, payload), "data_o");
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (!test_ok) begin
      failed_tests++;
    end
    $display("test %0d %s: %s", test_count, name, test_ok ? "passed" : "failed");
  endtask

  initial begin
    int    fd;
    int    n_read;
    int    n_fields;
    string line;
    string op;
    int    id;
    int    payload;
    int    mask;
    int    expected;
    rst_ni = 1'b0;
    reserve_id_i = '0;
    reserve_ready_i = 1'b0;
    in_valid_i = 1'b0;
    data_i = '0;
    release_en_i = '0;
    out_ready_i = 1'b0;
    error_count = 0;
    test_count = 0;
    failed_tests = 0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // State right after reset
    test_ok = 1'b1;
    @(negedge clk_i);
    check_value(out_valid_o, 0, "out_valid_o");
    check_value(address_released_onehot_o, 0, "address_released_onehot_o");
    check_value(reserve_valid_o, 1, "reserve_valid_o");
    check_value(reserve_addr_o, 0, "reserve_addr_o");
    check_value(in_ready_o, 0, "in_ready_o");
    finish_test("RESET");

    fd = $fopen("test/resp_bank_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/resp_bank_input.txt for reading");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n_read = $fgets(line, fd);
        n_fields = $sscanf(line, "%s %h %h %h %h", op, id, payload, mask, expected);
        if (n_read > 0 && n_fields == 5 && line.getc(0) != "#") begin
          test_ok = 1'b1;
          case (op)
            "RES":   reserve_slot(id, expected);
            "MSG":   send_message(id, payload, expected);
            "REL":   set_release(mask, expected);
            "OUT":   take_output(id, payload, expected);
            "STALL": hold_output(id, payload, expected);
            default: begin
              $display("Unknown opcode %s in the stimulus file", op);
              error_count++;
              test_ok = 1'b0;
            end
          endcase
          finish_test(op);
        end
      end
      $fclose(fd);
    end

    if (released_q.size() != 0) begin
      $display("%0d released slots never matched an output", released_q.size());
      error_count++;
    end
    $display("Tests run %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: test/resp_bank_input.txt
# op id payload release_mask expected, all fields in hex
# expected is RES address, MSG in_ready, REL out_valid, OUT released slot, STALL cycles
RES 1 0000 0000 0
RES 1 0000 0000 1
RES 2 0000 0000 2
RES 0 0000 0000 3
MSG 3 1111 0000 0
MSG 1 0aa1 0000 1
MSG 1 0aa2 0000 1
MSG 1 0aa3 0000 0
MSG 2 0bb1 0000 1
MSG 0 0cc1 0000 1
REL 0 0000 0002 0
REL 0 0000 0003 1
OUT 1 0aa1 0000 0001
OUT 1 0aa2 0000 0002
RES 3 0000 0000 0
RES 2 0000 0000 1
MSG 3 0dd1 0000 1
MSG 2 0bb2 0000 1
REL 0 0000 000f 1
STALL 0 0cc1 0000 3
OUT 0 0cc1 0000 0008
OUT 2 0bb1 0000 0004
OUT 2 0bb2 0000 0002
OUT 3 0dd1 0000 0001
RES 1 0000 0000 0
REL 0 0000 0000 0

// File: project.f
source/resp_bank_pkg.sv
source/slot_allocator.sv
source/id_slot_queue.sv
source/message_store.sv
source/release_arbiter.sv
source/write_resp_bank.sv
test/tb_write_resp_bank.sv

// File: Bender.yml
package:
  name: write_resp_bank

sources:
  - source/resp_bank_pkg.sv
  - source/slot_allocator.sv
  - source/id_slot_queue.sv
  - source/message_store.sv
  - source/release_arbiter.sv
  - source/write_resp_bank.sv
  - target: test
    files:
      - test/tb_write_resp_bank.sv
